// ==== include/obi_params.svh ====
// OBI memory subsystem sizing
// Address and ID widths, memory depth and request FIFO depth shared by
// the bus types and the RTL blocks

`ifndef OBI_PARAMS_SVH
`define OBI_PARAMS_SVH

// ---------------------------------------------------------------------------
// Bus widths
// ---------------------------------------------------------------------------

// Byte address width of the OBI address phase
`define OBI_ADDR_W 32

// Transaction ID width, echoed back as rid
`define OBI_AID_W 4

// ---------------------------------------------------------------------------
// Storage sizes
// ---------------------------------------------------------------------------

// 64 words of 32 bits, byte addresses 0 to 255
`define MEM_WORDS_LOG2 6

// Request FIFO entries between generator and slave
`define FIFO_DEPTH 4

`endif // OBI_PARAMS_SVH

// ==== hdl/obi_pkg.sv ====
// OBI bus transaction types
// Address phase and response phase of the data-side OBI port, each
// carried as one packed struct

`default_nettype none

`include "obi_params.svh"

package obi_pkg;

    // -----------------------------------------------------------------------
    // Address phase
    // -----------------------------------------------------------------------
    typedef struct packed {
        // Request strobe and its inverted parity companion
        logic                   req;
        logic                   reqpar;
        logic                   we;
        // One enable per byte lane
        logic [3:0]             be;
        logic [`OBI_ADDR_W-1:0] addr;
        logic [31:0]            wdata;
        logic [`OBI_AID_W-1:0]  aid;
        // User sidebands, tied off by the generator
        logic                   auser;
        logic                   wuser;
    } obi_req_t;

    // -----------------------------------------------------------------------
    // Response phase
    // -----------------------------------------------------------------------
    typedef struct packed {
        // One-cycle strobe, rready is tied high so never held
        logic                  rvalid;
        logic                  rvalidpar;
        logic [31:0]           rdata;
        // Even parity per byte of rdata
        logic [3:0]            rchk;
        logic                  err;
        // Echo of the address phase aid
        logic [`OBI_AID_W-1:0] rid;
    } obi_rsp_t;

endpackage : obi_pkg

`default_nettype wire

// ==== hdl/mem_pkg.sv ====
// Memory-side types
// External command format and the memory word with its byte view

`default_nettype none

`include "obi_params.svh"

package mem_pkg;

    // -----------------------------------------------------------------------
    // External command, qualified by a one-cycle strobe outside the struct
    // -----------------------------------------------------------------------
    typedef struct packed {
        logic                   we;
        logic [3:0]             be;
        logic [`OBI_ADDR_W-1:0] addr;
        logic [31:0]            wdata;
        logic [`OBI_AID_W-1:0]  aid;
    } mem_cmd_t;

    // -----------------------------------------------------------------------
    // Memory word
    // -----------------------------------------------------------------------
    // Whole word for reads, byte lanes for byte-enable merging
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] bytes;
    } mem_word_u;

endpackage : mem_pkg

`default_nettype wire

// ==== hdl/obi_req_gen.sv ====
// OBI request generator
// Registers each strobed external command into an OBI address-phase item,
// driving the request parity and the user sideband tie-offs

`default_nettype none

module obi_req_gen (
    input  wire logic              clk_i,
    input  wire logic              reset_i,
    input  wire logic              cmd_valid_i,
    input  wire mem_pkg::mem_cmd_t cmd_i,
    output obi_pkg::obi_req_t      req_o
);

    // Request strobe, one cycle behind the command strobe
    logic req_q;

    // Captured command payload
    mem_pkg::mem_cmd_t cmd_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            req_q <= 1'b0;
        end else begin
            req_q <= cmd_valid_i;
        end
    end

    // Payload only loads on a strobe
    always_ff @(posedge clk_i) begin
        if (cmd_valid_i) begin
            cmd_q <= cmd_i;
        end
    end

    // -----------------------------------------------------------------------
    // Address phase assembly
    // -----------------------------------------------------------------------
    always_comb begin
        req_o.req    = req_q;
        // Parity companion is the inverse of req
        req_o.reqpar = ~req_q;
        req_o.we     = cmd_q.we;
        req_o.be     = cmd_q.be;
        req_o.addr   = cmd_q.addr;
        req_o.wdata  = cmd_q.wdata;
        req_o.aid    = cmd_q.aid;
        // Unused user sidebands
        req_o.auser  = 1'b0;
        req_o.wuser  = 1'b0;
    end

    // A pushed item has its parity inverted and a fully defined payload
    a_req_item_valid : assert property (@(posedge clk_i) disable iff (reset_i)
        req_o.req |-> (!req_o.reqpar && !$isunknown(req_o)))
        else $error("obi_req_gen: request with bad parity or undefined payload");

endmodule : obi_req_gen

`default_nettype wire

// ==== hdl/obi_req_fifo.sv ====
// OBI request FIFO
// Circular buffer between the request generator and the memory slave,
// pops on grant and drops pushes into a full buffer with a sticky flag

`default_nettype none

`include "obi_params.svh"

module obi_req_fifo (
    input  wire logic              clk_i,
    input  wire logic              reset_i,
    input  wire obi_pkg::obi_req_t push_i,
    input  wire logic              gnt_i,
    output obi_pkg::obi_req_t      head_o,
    output logic                   overflow_o
);

    typedef logic [$clog2(`FIFO_DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(`FIFO_DEPTH+1)-1:0] cnt_t;

    // Entry storage, no reset needed
    obi_pkg::obi_req_t buf_q [`FIFO_DEPTH];

    ptr_t wr_ptr_q;
    ptr_t rd_ptr_q;
    cnt_t count_q;
    logic overflow_q;

    logic empty;
    logic full;
    logic push_ok;
    logic pop;

    assign empty   = (count_q == '0);
    assign full    = (count_q == cnt_t'(`FIFO_DEPTH));
    assign push_ok = push_i.req && !full;
    // Grant only comes while the head is valid
    assign pop     = gnt_i && !empty;

    // -----------------------------------------------------------------------
    // Pointers, count and overflow
    // -----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            overflow_q <= 1'b0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= (wr_ptr_q == ptr_t'(`FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == ptr_t'(`FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Net occupancy change
            case ({push_ok, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            // Sticky until reset, the strobe has no back-pressure
            if (push_i.req && full) begin
                overflow_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            buf_q[wr_ptr_q] <= push_i;
        end
    end

    // Head item, req marks a non-empty buffer
    always_comb begin
        head_o        = buf_q[rd_ptr_q];
        head_o.req    = !empty;
        head_o.reqpar = empty;
    end

    assign overflow_o = overflow_q;

    // Slave must never grant an empty buffer
    a_no_pop_empty : assert property (@(posedge clk_i) disable iff (reset_i)
        gnt_i |-> !empty)
        else $error("obi_req_fifo: grant while empty");

endmodule : obi_req_fifo

`default_nettype wire

// ==== hdl/obi_mem_slave.sv ====
// OBI memory slave
// Grants one access every two cycles over a 64-word memory, merges byte
// enabled writes, flags out-of-range addresses and returns parity-protected
// responses

`default_nettype none

`include "obi_params.svh"

module obi_mem_slave (
    input  wire logic              clk_i,
    input  wire logic              reset_i,
    input  wire obi_pkg::obi_req_t req_i,
    output logic                   gnt_o,
    output obi_pkg::obi_rsp_t      rsp_o
);

    // Grant when idle, response cycle doubles as the gap
    typedef enum logic {
        st_idle,
        st_gap
    } state_t;

    state_t state_q;

    mem_pkg::mem_word_u mem_q [1 << `MEM_WORDS_LOG2];

    logic [`MEM_WORDS_LOG2-1:0] word_idx;
    logic                       in_range;
    mem_pkg::mem_word_u         wdata_view;

    // Registered response payload
    logic                  rvalid_q;
    mem_pkg::mem_word_u    rdata_q;
    logic                  err_q;
    logic [`OBI_AID_W-1:0] rid_q;

    // Word index from the byte address
    assign word_idx = req_i.addr[`MEM_WORDS_LOG2+1:2];
    // Anything above byte 255 is out of range
    assign in_range = (req_i.addr[`OBI_ADDR_W-1:`MEM_WORDS_LOG2+2] == '0);
    assign gnt_o    = req_i.req && (state_q == st_idle);

    always_comb begin
        wdata_view.word = req_i.wdata;
    end

    // -----------------------------------------------------------------------
    // Grant/respond FSM
    // -----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q  <= st_idle;
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= gnt_o;
            case (state_q)
                st_idle: state_q <= gnt_o ? st_gap : st_idle;
                default: state_q <= st_idle;
            endcase
        end
    end

    // Memory is cleared on reset, writes merge only the enabled lanes
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < (1 << `MEM_WORDS_LOG2); i++) begin
                mem_q[i].word <= '0;
            end
        end else if (gnt_o && req_i.we && in_range) begin
            for (int b = 0; b < 4; b++) begin
                if (req_i.be[b]) begin
                    mem_q[word_idx].bytes[b] <= wdata_view.bytes[b];
                end
            end
        end
    end

    // Response payload captured at grant
    always_ff @(posedge clk_i) begin
        if (gnt_o) begin
            rid_q <= req_i.aid;
            err_q <= !in_range;
            // Writes and errors return zero data
            rdata_q.word <= (in_range && !req_i.we) ? mem_q[word_idx].word : '0;
        end
    end

    // -----------------------------------------------------------------------
    // Response assembly
    // -----------------------------------------------------------------------
    always_comb begin
        rsp_o.rvalid    = rvalid_q;
        rsp_o.rvalidpar = ~rvalid_q;
        rsp_o.rdata     = rdata_q.word;
        rsp_o.err       = err_q;
        rsp_o.rid       = rid_q;
        // Even parity per byte lane
        for (int b = 0; b < 4; b++) begin
            rsp_o.rchk[b] = ^rdata_q.bytes[b];
        end
    end

    // Response one cycle after the grant, and no new grant in that gap cycle
    a_rvalid_after_gnt : assert property (@(posedge clk_i) disable iff (reset_i)
        gnt_o |=> (rsp_o.rvalid && !gnt_o))
        else $error("obi_mem_slave: no response or no gap after gnt");

endmodule : obi_mem_slave

`default_nettype wire

// ==== hdl/obi_mem_wrap.sv ====
// OBI data-side memory subsystem top
// Command strobe in, generator feeds the request FIFO, the memory slave
// drains it and drives the response phase out

`default_nettype none

module obi_mem_wrap (
    input  wire logic              clk_i,
    input  wire logic              reset_i,
    input  wire logic              cmd_valid_i,
    input  wire mem_pkg::mem_cmd_t cmd_i,
    output obi_pkg::obi_rsp_t      rsp_o,
    output logic                   overflow_o
);

    // Generator to FIFO, FIFO head to slave
    obi_pkg::obi_req_t gen_req;
    obi_pkg::obi_req_t fifo_head;
    logic              mem_gnt;

    // -----------------------------------------------------------------------
    // Producer, buffer, consumer
    // -----------------------------------------------------------------------
    obi_req_gen req_gen_i (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .req_o       (gen_req)
    );

    obi_req_fifo req_fifo_i (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .push_i     (gen_req),
        .gnt_i      (mem_gnt),
        .head_o     (fifo_head),
        .overflow_o (overflow_o)
    );

    obi_mem_slave mem_slave_i (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .req_i   (fifo_head),
        .gnt_o   (mem_gnt),
        .rsp_o   (rsp_o)
    );

endmodule : obi_mem_wrap

`default_nettype wire

// ==== tb/obi_mem_checker.sv ====
// OBI memory subsystem response checker
// Holds the expected record of every issued command, matches each
// response to it by rid and checks data, error, parity and latency

`default_nettype none

`include "obi_params.svh"

module obi_mem_checker (
    input wire logic              clk_i,
    input wire logic              reset_i,
    input wire obi_pkg::obi_rsp_t rsp_i,
    input wire logic              overflow_i
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int PERIOD_NS = 20;
    // Idle system, strobe sample edge to response sample edge
    localparam int MAX_LAT   = 3;

    typedef struct {
        string                 name;
        logic [`OBI_AID_W-1:0] aid;
        logic [31:0]           rdata;
        logic                  err;
        bit                    timed;
        time                   t_sample;
    } exp_t;

    // Outstanding commands in issue order, looked up by aid
    exp_t exp_q [$];

    int data_errs   = 0;
    int parity_errs = 0;
    int order_errs  = 0;
    int timing_errs = 0;
    int dropped     = 0;

    // Even parity per byte lane, counted bit by bit
    function automatic logic [3:0] lane_parity(input logic [31:0] data);
        logic [3:0] par;
        int         ones;
        for (int b = 0; b < 4; b++) begin
            ones = 0;
            for (int k = 0; k < 8; k++) begin
                ones += int'(data[8*b+k]);
            end
            par[b] = ones[0];
        end
        return par;
    endfunction

    function automatic void add_expect(input string name, input logic [`OBI_AID_W-1:0] aid,
                                       input logic [31:0] rdata, input logic err,
                                       input bit timed, input time t_sample);
        exp_t e;
        e.name     = name;
        e.aid      = aid;
        e.rdata    = rdata;
        e.err      = err;
        e.timed    = timed;
        e.t_sample = t_sample;
        exp_q.push_back(e);
    endfunction

    function automatic int pending();
        return exp_q.size();
    endfunction

    // -----------------------------------------------------------------------
    // Response matching
    // -----------------------------------------------------------------------
    task automatic check_response();
        int   idx;
        int   lat;
        exp_t e;
        idx = -1;
        for (int i = 0; i < exp_q.size(); i++) begin
            if (exp_q[i].aid == rsp_i.rid) begin
                idx = i;
                break;
            end
        end
        if (idx < 0) begin
            order_errs++;
            $display("Response with rid %0h matches no outstanding command", rsp_i.rid);
            return;
        end
        // Older entries were skipped, only a FIFO drop explains that
        for (int i = 0; i < idx; i++) begin
            e = exp_q.pop_front();
            if (overflow_i) begin
                dropped++;
            end else begin
                order_errs++;
                $display("No response for %s (aid %0h) and no overflow to explain it",
                         e.name, e.aid);
            end
        end
        e = exp_q.pop_front();
        if (rsp_i.rdata !== e.rdata) begin
            data_errs++;
            $display("FAIL %s rdata: expected %h actual %h", e.name, e.rdata, rsp_i.rdata);
        end
        if (rsp_i.err !== e.err) begin
            data_errs++;
            $display("FAIL %s err: expected %b actual %b", e.name, e.err, rsp_i.err);
        end
        // Parity of the data the command should have returned
        if (rsp_i.rchk !== lane_parity(e.rdata)) begin
            parity_errs++;
            $display("FAIL %s rchk: expected %h actual %h", e.name,
                     lane_parity(e.rdata), rsp_i.rchk);
        end
        if (e.timed) begin
            lat = int'(($time - e.t_sample) / PERIOD_NS);
            if (lat > MAX_LAT) begin
                timing_errs++;
                $display("FAIL %s latency: expected %0d actual %0d", e.name, MAX_LAT, lat);
            end
        end
    endtask

    // Responses are stable between edges, sampled on the rising edge
    always @(posedge clk_i) begin
        if (!reset_i) begin
            if (rsp_i.rvalidpar !== ~rsp_i.rvalid) begin
                parity_errs++;
                $display("FAIL %s rvalidpar: expected %b actual %b",
                         rsp_i.rvalid ? "response" : "idle", ~rsp_i.rvalid, rsp_i.rvalidpar);
            end
            if (rsp_i.rvalid === 1'b1) begin
                check_response();
            end
        end
    end

    // -----------------------------------------------------------------------
    // Closing summary
    // -----------------------------------------------------------------------
    task automatic report(input int load_errs, input int timeouts, output int total);
        // Burst in the stimulus must overflow the FIFO
        if (overflow_i !== 1'b1) begin
            order_errs++;
            $display("Overflow flag was never raised by the burst");
        end else if (dropped == 0) begin
            order_errs++;
            $display("Overflow flag is set but every command got a response");
        end
        if (exp_q.size() != 0) begin
            order_errs += exp_q.size();
            $display("%0d commands still wait for a response", exp_q.size());
        end
        total = data_errs + parity_errs + order_errs + timing_errs + load_errs + timeouts;
        $display("errors: data=%0d parity=%0d order=%0d timing=%0d load=%0d timeout=%0d dropped=%0d",
                 data_errs, parity_errs, order_errs, timing_errs, load_errs, timeouts, dropped);
    endtask

endmodule : obi_mem_checker

`default_nettype wire

// ==== tb/tb_obi_mem_wrap.sv ====
// OBI memory subsystem testbench
// Reads commands and expected results from the stim file, drives the
// command strobe and bounds the run with a cycle counter

`default_nettype none

`include "obi_params.svh"

module tb_obi_mem_wrap;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int PERIOD_NS    = 20;
    localparam int DRIVE_DLY_NS = 1;
    localparam int MAX_CMDS     = 64;

    logic              clk_i;
    logic              reset_i;
    logic              cmd_valid_i;
    mem_pkg::mem_cmd_t cmd_i;
    obi_pkg::obi_rsp_t rsp_o;
    logic              overflow_o;

    // Stimulus table
    string             name_a      [MAX_CMDS];
    mem_pkg::mem_cmd_t cmd_a       [MAX_CMDS];
    logic [31:0]       exp_rdata_a [MAX_CMDS];
    logic              exp_err_a   [MAX_CMDS];
    int                gap_a       [MAX_CMDS];

    int n_cmds    = 0;
    int gap_sum   = 0;
    int load_errs = 0;
    int timeouts  = 0;
    int cycle     = 0;
    int limit     = 0;

    obi_mem_wrap uut (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .rsp_o       (rsp_o),
        .overflow_o  (overflow_o)
    );

    obi_mem_checker chk (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .rsp_i      (rsp_o),
        .overflow_i (overflow_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(PERIOD_NS / 2) clk_i = ~clk_i;
    end

    // -----------------------------------------------------------------------
    // Stim file loading
    // -----------------------------------------------------------------------
    task automatic load_stim();
        int                     fd;
        int                     fields;
        string                  line;
        string                  name;
        logic                   we;
        logic [3:0]             be;
        logic [`OBI_ADDR_W-1:0] addr;
        logic [31:0]            wdata;
        logic [`OBI_AID_W-1:0]  aid;
        logic [31:0]            rdata;
        logic                   err;
        int                     gap;
        fd = $fopen("tb/obi_mem_stim.txt", "r");
        if (fd == 0) begin
            load_errs++;
            $display("Cannot open the stim file tb/obi_mem_stim.txt");
            return;
        end
        while ($fgets(line, fd) != 0 && n_cmds < MAX_CMDS) begin
            // Skip blank and comment lines
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%s %h %h %h %h %h %h %h %d",
                             name, we, be, addr, wdata, aid, rdata, err, gap);
            if (fields != 9) begin
                load_errs++;
                $display("Malformed stim line: %s", line);
                continue;
            end
            name_a[n_cmds]      = name;
            cmd_a[n_cmds].we    = we;
            cmd_a[n_cmds].be    = be;
            cmd_a[n_cmds].addr  = addr;
            cmd_a[n_cmds].wdata = wdata;
            cmd_a[n_cmds].aid   = aid;
            exp_rdata_a[n_cmds] = rdata;
            exp_err_a[n_cmds]   = err;
            gap_a[n_cmds]       = gap;
            gap_sum            += gap;
            n_cmds++;
        end
        $fclose(fd);
    endtask

    // Advance to just past the next rising edge
    task automatic step_cycle();
        @(posedge clk_i);
        #DRIVE_DLY_NS;
    endtask

    task automatic issue_cmd(input int i);
        bit timed;
        // Only a command into an idle system has a fixed latency
        timed       = (i == 0) || (gap_a[i-1] >= 3);
        cmd_valid_i = 1'b1;
        cmd_i       = cmd_a[i];
        chk.add_expect(name_a[i], cmd_a[i].aid, exp_rdata_a[i], exp_err_a[i], timed,
                       $time - DRIVE_DLY_NS + PERIOD_NS);
        step_cycle();
        if (gap_a[i] > 0) begin
            cmd_valid_i = 1'b0;
            repeat (gap_a[i]) step_cycle();
        end
    endtask

    task automatic finish_run();
        int total;
        chk.report(load_errs, timeouts, total);
        if (total == 0 && n_cmds > 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    // Cycle counter with run limit
    always @(posedge clk_i) begin
        cycle <= cycle + 1;
        if (limit > 0 && cycle >= limit) begin
            timeouts++;
            $display("Run stopped after %0d cycles with responses still outstanding", cycle);
            finish_run();
        end
    end

    // -----------------------------------------------------------------------
    // Main sequence
    // -----------------------------------------------------------------------
    initial begin
        reset_i     = 1'b1;
        cmd_valid_i = 1'b0;
        cmd_i       = '0;
        load_stim();
        if (n_cmds == 0) begin
            $display("No commands were read from the stim file");
        end
        limit = 4 * n_cmds + gap_sum + 20;
        repeat (3) step_cycle();
        reset_i = 1'b0;
        for (int i = 0; i < n_cmds; i++) begin
            issue_cmd(i);
        end
        cmd_valid_i = 1'b0;
        // Wait for the last response, the cycle counter bounds this
        while (chk.pending() != 0) begin
            step_cycle();
        end
        finish_run();
    end

endmodule : tb_obi_mem_wrap

`default_nettype wire

// ==== tb/obi_mem_stim.txt ====
# name we be addr wdata aid exp_rdata exp_err gap (all hex except gap, in decimal cycles)
# Writes and out-of-range accesses expect rdata zero
wr_full   1 f 00000010 deadbeef 1 00000000 0 5
rd_full   0 f 00000010 00000000 2 deadbeef 0 5
wr_base   1 f 00000020 11223344 3 00000000 0 5
wr_part   1 5 00000020 aabbccdd 4 00000000 0 5
rd_part   0 f 00000020 00000000 5 11bb33dd 0 5
wr_oor    1 f 00000120 cafef00d 6 00000000 1 5
rd_oor    0 f 00000120 00000000 7 00000000 1 5
rd_alias  0 f 00000020 00000000 8 11bb33dd 0 5
rd_spaced 0 f 00000010 00000000 9 deadbeef 0 8
burst_0   0 f 00000010 00000000 0 deadbeef 0 0
burst_1   0 f 00000020 00000000 1 11bb33dd 0 0
burst_2   0 f 00000000 00000000 2 00000000 0 0
burst_3   0 f 00000010 00000000 3 deadbeef 0 0
burst_4   0 f 00000020 00000000 4 11bb33dd 0 0
burst_5   0 f 00000000 00000000 5 00000000 0 0
burst_6   0 f 00000010 00000000 6 deadbeef 0 0
burst_7   0 f 00000020 00000000 7 11bb33dd 0 0
burst_8   0 f 00000000 00000000 8 00000000 0 0
burst_9   0 f 00000010 00000000 9 deadbeef 0 0
burst_a   0 f 00000020 00000000 a 11bb33dd 0 0
burst_b   0 f 00000000 00000000 b 00000000 0 0
rd_final  0 f 00000020 00000000 c 11bb33dd 0 10

// ==== obi_mem_wrap.f ====
+incdir+include
hdl/obi_pkg.sv
hdl/mem_pkg.sv
hdl/obi_req_gen.sv
hdl/obi_req_fifo.sv
hdl/obi_mem_slave.sv
hdl/obi_mem_wrap.sv
tb/obi_mem_checker.sv
tb/tb_obi_mem_wrap.sv
